// ==== hdc_pkg.sv ====
package hdc_pkg;

    // --------------------------------------------------
    // sizes
    // --------------------------------------------------

    // hypervector width in bits
    localparam int DIM = 64;

    // xorshift output word and words per hypervector
    localparam int WORD_W   = 32;
    localparam int HV_WORDS = DIM / WORD_W;

    // encoder lanes, one per core
    localparam int CORE_NUM = 2;

    // item memory
    localparam int ITEM_DEPTH = 16;
    localparam int ITEM_AW    = 4;

    // one instruction per lane
    localparam int LANE_W = 16;

    // signed per-bit counter, and the cross-core sum
    localparam int CNT_W = 8;
    localparam int SUM_W = 9;

    // --------------------------------------------------
    // constants
    // --------------------------------------------------

    // xorshift32 start value
    localparam logic [31:0] XS_SEED = 32'h2545f491;

    // register map, byte addresses
    localparam logic [31:0] REG_MODE_ADDR  = 32'd0;
    localparam logic [31:0] REG_COUNT_ADDR = 32'd4;

    // --------------------------------------------------
    // types
    // --------------------------------------------------

    typedef logic [DIM-1:0] hv_t;

    // lane instruction, item in the low nibble
    typedef struct packed {
        logic [7:0]         rsvd;
        logic [3:0]         rot;
        logic [ITEM_AW-1:0] item;
    } instr_t;

    // broadcast write into every item memory
    typedef struct packed {
        logic               valid;
        logic [ITEM_AW-1:0] addr;
        hv_t                data;
    } item_wr_t;

    // one two's complement counter per dimension
    typedef struct packed {
        logic [DIM-1:0][CNT_W-1:0] cnt;
    } core_acc_t;

endpackage

// ==== axil_regs.sv ====
`timescale 1ns/1ps

module axil_regs
    import hdc_pkg::*;
(
    input  logic             AXIS_ACLK,
    input  logic             S_AXI_ARESETN,

    input  logic [31:0]      s_axi_awaddr,
    input  logic             s_axi_awvalid,
    output logic             s_axi_awready,
    input  logic [31:0]      s_axi_wdata,
    input  logic             s_axi_wvalid,
    output logic             s_axi_wready,
    output logic             s_axi_bvalid,
    output logic [1:0]       s_axi_bresp,
    input  logic             s_axi_bready,
    input  logic [31:0]      s_axi_araddr,
    input  logic             s_axi_arvalid,
    output logic             s_axi_arready,
    output logic [31:0]      s_axi_rdata,
    output logic             s_axi_rvalid,
    output logic [1:0]       s_axi_rresp,
    input  logic             s_axi_rready,

    input  logic             gen_done,
    output logic             gen,
    output logic             run,
    output logic [ITEM_AW:0] item_count
);

    // AW and W land in either order, both end up in ST_WR
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_AW,
        ST_W,
        ST_WR,
        ST_B,
        ST_AR,
        ST_R
    } state_t;

    state_t      state;
    logic [31:0] waddr;
    logic [31:0] wdata;
    logic [31:0] raddr;

    // --------------------------------------------------
    // handshakes
    // --------------------------------------------------

    assign s_axi_awready = (state == ST_IDLE) || (state == ST_W);
    assign s_axi_wready  = (state == ST_IDLE) || (state == ST_AW);
    // a pending write takes priority over a read
    assign s_axi_arready = (state == ST_IDLE) && !s_axi_awvalid && !s_axi_wvalid;
    assign s_axi_bvalid  = (state == ST_B);
    assign s_axi_rvalid  = (state == ST_R);
    // always OKAY
    assign s_axi_bresp   = 2'b00;
    assign s_axi_rresp   = 2'b00;

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (s_axi_awvalid && s_axi_wvalid) begin
                        state <= ST_WR;
                    end else if (s_axi_awvalid) begin
                        state <= ST_AW;
                    end else if (s_axi_wvalid) begin
                        state <= ST_W;
                    end else if (s_axi_arvalid) begin
                        state <= ST_AR;
                    end
                end
                // address held, wait for data
                ST_AW: begin
                    if (s_axi_wvalid) begin
                        state <= ST_WR;
                    end
                end
                // data held, wait for address
                ST_W: begin
                    if (s_axi_awvalid) begin
                        state <= ST_WR;
                    end
                end
                // single register update cycle
                ST_WR:   state <= ST_B;
                ST_B: begin
                    if (s_axi_bready) begin
                        state <= ST_IDLE;
                    end
                end
                // decode cycle before rvalid
                ST_AR:   state <= ST_R;
                ST_R: begin
                    if (s_axi_rready) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // --------------------------------------------------
    // address / data capture and read mux
    // --------------------------------------------------

    always_ff @(posedge AXIS_ACLK) begin
        if (s_axi_awvalid && s_axi_awready) begin
            waddr <= s_axi_awaddr;
        end
        if (s_axi_wvalid && s_axi_wready) begin
            wdata <= s_axi_wdata;
        end
        if (s_axi_arvalid && s_axi_arready) begin
            raddr <= s_axi_araddr;
        end
        // zero-extended register values, unmapped reads give 0
        if (state == ST_AR) begin
            case (raddr)
                REG_MODE_ADDR:  s_axi_rdata <= {30'd0, run, gen};
                REG_COUNT_ADDR: s_axi_rdata <= {{(31-ITEM_AW){1'b0}}, item_count};
                default:        s_axi_rdata <= '0;
            endcase
        end
    end

    // --------------------------------------------------
    // mode and count registers
    // --------------------------------------------------

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            gen        <= 1'b0;
            run        <= 1'b0;
            item_count <= (ITEM_AW+1)'(ITEM_DEPTH);
        end else begin
            // generator finished, leave gen mode
            if (gen_done) begin
                gen <= 1'b0;
            end
            // a host write in the same cycle wins
            if (state == ST_WR) begin
                case (waddr)
                    REG_MODE_ADDR: begin
                        run <= wdata[1];
                        gen <= wdata[0];
                    end
                    REG_COUNT_ADDR: item_count <= wdata[ITEM_AW:0];
                    default: ;
                endcase
            end
        end
    end

    // write response and read data never overlap
    a_b_r_excl: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        !(s_axi_bvalid && s_axi_rvalid));

endmodule

// ==== item_gen.sv ====
`timescale 1ns/1ps

module item_gen
    import hdc_pkg::*;
(
    input  logic             AXIS_ACLK,
    input  logic             S_AXI_ARESETN,
    input  logic             gen,
    input  logic [ITEM_AW:0] item_count,
    output item_wr_t         item_wr,
    output logic             gen_done
);

    logic [WORD_W-1:0]           xs_q;
    logic [WORD_W-1:0]           xs_cur;
    logic [WORD_W-1:0]           xs_nxt;
    logic [$clog2(HV_WORDS)-1:0] word_cnt;
    logic [ITEM_AW-1:0]          addr_cnt;
    hv_t                         hv_buf;
    logic                        started;
    logic                        finished;
    logic                        active;
    logic                        last_word;
    logic                        last_item;

    // stepping while gen is up and the table is not yet full
    assign active = gen && !finished;

    // first gen cycle restarts from the seed
    assign xs_cur = started ? xs_q : XS_SEED;

    // xorshift32, shifts 13 / 17 / 5
    always_comb begin
        xs_nxt = xs_cur ^ (xs_cur << 13);
        xs_nxt = xs_nxt ^ (xs_nxt >> 17);
        xs_nxt = xs_nxt ^ (xs_nxt << 5);
    end

    assign last_word = (word_cnt == $bits(word_cnt)'(HV_WORDS - 1));
    assign last_item = ({1'b0, addr_cnt} == item_count - 1'b1);

    // --------------------------------------------------
    // word assembly and memory write
    // --------------------------------------------------

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !gen) begin
            started       <= 1'b0;
            finished      <= 1'b0;
            word_cnt      <= '0;
            addr_cnt      <= '0;
            item_wr.valid <= 1'b0;
            gen_done      <= 1'b0;
        end else begin
            item_wr.valid <= 1'b0;
            gen_done      <= 1'b0;
            if (active) begin
                started <= 1'b1;
                xs_q    <= xs_nxt;
                // words shift in from the top, first word ends lowest
                hv_buf  <= {xs_nxt, hv_buf[DIM-1:WORD_W]};
                if (last_word) begin
                    word_cnt      <= '0;
                    addr_cnt      <= addr_cnt + 1'b1;
                    item_wr.valid <= 1'b1;
                    item_wr.addr  <= addr_cnt;
                    item_wr.data  <= {xs_nxt, hv_buf[DIM-1:WORD_W]};
                    // last item, tell the register block
                    if (last_item) begin
                        finished <= 1'b1;
                        gen_done <= 1'b1;
                    end
                end else begin
                    word_cnt <= word_cnt + 1'b1;
                end
            end
        end
    end

    // writes stay inside the programmed table
    a_addr_range: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        item_wr.valid |-> ({1'b0, item_wr.addr} < item_count));

endmodule

// ==== hdc_core.sv ====
`timescale 1ns/1ps

module hdc_core
    import hdc_pkg::*;
(
    input  logic      AXIS_ACLK,
    input  logic      S_AXI_ARESETN,
    input  item_wr_t  item_wr,
    input  instr_t    instr,
    input  logic      beat,
    input  logic      last,
    output core_acc_t result,
    output logic      result_valid
);

    localparam logic [CNT_W-1:0] CNT_MAX = {1'b0, {(CNT_W-1){1'b1}}};
    localparam logic [CNT_W-1:0] CNT_MIN = {1'b1, {(CNT_W-1){1'b0}}};

    hv_t              mem [ITEM_DEPTH];
    hv_t              item_hv;
    hv_t              rot_hv;
    logic [2*DIM-1:0] rot_dbl;
    core_acc_t        acc_nxt;
    logic [DIM-1:0]   ovf;

    // --------------------------------------------------
    // item memory
    // --------------------------------------------------

    // filled by the broadcast generator writes
    always_ff @(posedge AXIS_ACLK) begin
        if (item_wr.valid) begin
            mem[item_wr.addr] <= item_wr.data;
        end
    end

    // asynchronous read of the instructed item
    assign item_hv = mem[instr.item];

    // rotate left, upper half of the doubled word
    assign rot_dbl = {item_hv, item_hv} << instr.rot;
    assign rot_hv  = rot_dbl[2*DIM-1:DIM];

    // --------------------------------------------------
    // accumulate
    // --------------------------------------------------

    // +1 for a set bit, -1 for a clear bit
    always_comb begin
        for (int b = 0; b < DIM; b++) begin
            if (rot_hv[b]) begin
                acc_nxt.cnt[b] = result.cnt[b] + 1'b1;
                ovf[b]         = (result.cnt[b] == CNT_MAX);
            end else begin
                acc_nxt.cnt[b] = result.cnt[b] - 1'b1;
                ovf[b]         = (result.cnt[b] == CNT_MIN);
            end
        end
    end

    // result is the live counter bank
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            result       <= '0;
            result_valid <= 1'b0;
        end else begin
            // final count is visible one cycle after the last beat
            result_valid <= beat && last;
            if (result_valid) begin
                // merge stage has it now, start the next packet clean
                result <= '0;
            end else if (beat) begin
                result <= acc_nxt;
            end
        end
    end

    // packet length keeps every counter inside CNT_W
    a_no_ovf: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        beat |-> (ovf == '0));

endmodule

// ==== bundle_merge.sv ====
`timescale 1ns/1ps

module bundle_merge
    import hdc_pkg::*;
(
    input  logic                     AXIS_ACLK,
    input  logic                     S_AXI_ARESETN,
    input  core_acc_t [CORE_NUM-1:0] results,
    input  logic [CORE_NUM-1:0]      result_valid,
    input  logic                     run,
    input  logic                     gen,
    input  logic                     m_axis_tready,
    output logic                     s_axis_tready,
    output hv_t                      m_axis_tdata,
    output logic                     m_axis_tvalid,
    output logic                     m_axis_tlast
);

    hv_t  sign_hv;
    logic res_vld;

    // cores run in lockstep
    assign res_vld = &result_valid;

    // --------------------------------------------------
    // cross-core sum and sign
    // --------------------------------------------------

    always_comb begin
        logic [SUM_W-1:0] sum;
        for (int b = 0; b < DIM; b++) begin
            sum = '0;
            // sign-extend each counter before adding
            for (int c = 0; c < CORE_NUM; c++) begin
                sum = sum + {{(SUM_W-CNT_W){results[c].cnt[b][CNT_W-1]}},
                             results[c].cnt[b]};
            end
            // 1 only for a strictly positive sum
            sign_hv[b] = !sum[SUM_W-1] && (sum != '0);
        end
    end

    // --------------------------------------------------
    // output stream
    // --------------------------------------------------

    // stall input while a result is in flight or waiting
    assign s_axis_tready = run && !gen && !res_vld && !m_axis_tvalid;

    // single-beat packets
    assign m_axis_tlast = m_axis_tvalid;

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            m_axis_tvalid <= 1'b0;
        end else if (res_vld) begin
            m_axis_tvalid <= 1'b1;
        end else if (m_axis_tready) begin
            m_axis_tvalid <= 1'b0;
        end
    end

    always_ff @(posedge AXIS_ACLK) begin
        if (res_vld) begin
            m_axis_tdata <= sign_hv;
        end
    end

    // held result does not change under back-pressure
    a_hold: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        (m_axis_tvalid && !m_axis_tready) |=> (m_axis_tvalid && $stable(m_axis_tdata)));

endmodule

// ==== hdc_top.sv ====
`timescale 1ns/1ps

module hdc_top
    import hdc_pkg::*;
(
    input  logic                       AXIS_ACLK,
    input  logic                       S_AXI_ARESETN,

    // AXI-Lite slave
    input  logic [31:0]                s_axi_awaddr,
    input  logic                       s_axi_awvalid,
    output logic                       s_axi_awready,
    input  logic [31:0]                s_axi_wdata,
    input  logic                       s_axi_wvalid,
    output logic                       s_axi_wready,
    output logic                       s_axi_bvalid,
    output logic [1:0]                 s_axi_bresp,
    input  logic                       s_axi_bready,
    input  logic [31:0]                s_axi_araddr,
    input  logic                       s_axi_arvalid,
    output logic                       s_axi_arready,
    output logic [31:0]                s_axi_rdata,
    output logic                       s_axi_rvalid,
    output logic [1:0]                 s_axi_rresp,
    input  logic                       s_axi_rready,

    // instruction stream in
    input  logic [CORE_NUM*LANE_W-1:0] s_axis_tdata,
    input  logic                       s_axis_tvalid,
    input  logic                       s_axis_tlast,
    output logic                       s_axis_tready,

    // encoded hypervector out
    output hv_t                        m_axis_tdata,
    output logic                       m_axis_tvalid,
    output logic                       m_axis_tlast,
    input  logic                       m_axis_tready
);

    logic                     gen;
    logic                     run;
    logic                     gen_done;
    logic [ITEM_AW:0]         item_count;
    item_wr_t                 item_wr;
    logic                     beat;
    instr_t [CORE_NUM-1:0]    lane;
    core_acc_t [CORE_NUM-1:0] results;
    logic [CORE_NUM-1:0]      result_valid;

    // --------------------------------------------------
    // control
    // --------------------------------------------------

    axil_regs i_axil_regs (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rready  (s_axi_rready),
        .gen_done      (gen_done),
        .gen           (gen),
        .run           (run),
        .item_count    (item_count)
    );

    // item table fill, same writes to every core
    item_gen i_item_gen (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .gen           (gen),
        .item_count    (item_count),
        .item_wr       (item_wr),
        .gen_done      (gen_done)
    );

    // --------------------------------------------------
    // cores
    // --------------------------------------------------

    // accepted input beat
    assign beat = s_axis_tvalid && s_axis_tready;

    for (genvar i = 0; i < CORE_NUM; i++) begin : g_core
        // lane i sits at bits 16*i +: 16
        assign lane[i] = s_axis_tdata[i*LANE_W +: LANE_W];

        hdc_core i_hdc_core (
            .AXIS_ACLK     (AXIS_ACLK),
            .S_AXI_ARESETN (S_AXI_ARESETN),
            .item_wr       (item_wr),
            .instr         (lane[i]),
            .beat          (beat),
            .last          (s_axis_tlast),
            .result        (results[i]),
            .result_valid  (result_valid[i])
        );
    end

    // sum, sign, output handshake and input back-pressure
    bundle_merge i_bundle_merge (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .results       (results),
        .result_valid  (result_valid),
        .run           (run),
        .gen           (gen),
        .m_axis_tready (m_axis_tready),
        .s_axis_tready (s_axis_tready),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tlast  (m_axis_tlast)
    );

endmodule

// ==== tb_hdc_top.sv ====
`timescale 1ns/1ps

module tb_hdc_top
    import hdc_pkg::*;
();

    // about 6 packets of 20 beats at 4 cycles each plus gen fills and AXI-Lite traffic
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int PKT_PER_ROUND  = 3;

    logic                       AXIS_ACLK;
    logic                       S_AXI_ARESETN;
    logic [31:0]                s_axi_awaddr;
    logic                       s_axi_awvalid;
    logic                       s_axi_awready;
    logic [31:0]                s_axi_wdata;
    logic                       s_axi_wvalid;
    logic                       s_axi_wready;
    logic                       s_axi_bvalid;
    logic [1:0]                 s_axi_bresp;
    logic                       s_axi_bready;
    logic [31:0]                s_axi_araddr;
    logic                       s_axi_arvalid;
    logic                       s_axi_arready;
    logic [31:0]                s_axi_rdata;
    logic                       s_axi_rvalid;
    logic [1:0]                 s_axi_rresp;
    logic                       s_axi_rready;
    logic [CORE_NUM*LANE_W-1:0] s_axis_tdata;
    logic                       s_axis_tvalid;
    logic                       s_axis_tlast;
    logic                       s_axis_tready;
    hv_t                        m_axis_tdata;
    logic                       m_axis_tvalid;
    logic                       m_axis_tlast;
    logic                       m_axis_tready;

    integer seed;
    int     cycles     = 0;
    int     sent       = 0;
    int     received   = 0;
    logic   prev_stall = 1'b0;
    hv_t    prev_data;
    hv_t    item_tab [ITEM_DEPTH];
    hv_t    exp_q [$];

    hdc_top i_hdc_top (.*);

    // free-running 100 ns clock
    initial begin
        AXIS_ACLK = 1'b0;
        forever #50 AXIS_ACLK = ~AXIS_ACLK;
    end

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------

    task automatic stop_run();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [DIM-1:0] got,
                         input logic [DIM-1:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    function automatic logic [31:0] rand_word();
        rand_word = $random(seed);
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        logic [31:0] r;
        r = $random(seed);
        return r % n;
    endfunction

    // advance one clock and redraw output ready (3 of 4 high)
    task automatic next_cycle();
        @(posedge AXIS_ACLK);
        #1;
        m_axis_tready = (rand_below(4) != 0);
    endtask

    // reference xorshift32 step
    function automatic logic [31:0] xs_step(input logic [31:0] v);
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // generator restarts from the seed so one table covers any count
    task automatic build_items();
        logic [31:0] x;
        logic [31:0] lo;
        logic [31:0] hi;
        x = XS_SEED;
        for (int k = 0; k < ITEM_DEPTH; k++) begin
            lo          = xs_step(x);
            hi          = xs_step(lo);
            x           = hi;
            item_tab[k] = {hi, lo};
        end
    endtask

    // --------------------------------------------------
    // AXI-Lite host
    // --------------------------------------------------

    // address and data in random order or together
    task automatic axil_write(input logic [31:0] addr, input logic [31:0] data);
        int unsigned order;
        logic        aw_hs;
        logic        w_hs;
        logic        aw_done;
        logic        w_done;
        order         = rand_below(3);
        aw_done       = 1'b0;
        w_done        = 1'b0;
        s_axi_awaddr  = addr;
        s_axi_wdata   = data;
        s_axi_awvalid = (order != 1);
        s_axi_wvalid  = (order != 2);
        while (!(aw_done && w_done)) begin
            @(negedge AXIS_ACLK);
            aw_hs = s_axi_awvalid && s_axi_awready;
            w_hs  = s_axi_wvalid && s_axi_wready;
            next_cycle();
            if (aw_hs) begin
                s_axi_awvalid = 1'b0;
                aw_done       = 1'b1;
            end
            if (w_hs) begin
                s_axi_wvalid = 1'b0;
                w_done       = 1'b1;
            end
            // second half follows the first
            if (aw_done && !w_done) begin
                s_axi_wvalid = 1'b1;
            end
            if (w_done && !aw_done) begin
                s_axi_awvalid = 1'b1;
            end
        end
        s_axi_bready = 1'b1;
        do @(negedge AXIS_ACLK); while (!s_axi_bvalid);
        check("s_axi_bresp", 64'(s_axi_bresp), 64'd0);
        next_cycle();
        s_axi_bready = 1'b0;
    endtask

    task automatic axil_read(input logic [31:0] addr, output logic [31:0] data);
        s_axi_araddr  = addr;
        s_axi_arvalid = 1'b1;
        do @(negedge AXIS_ACLK); while (!s_axi_arready);
        next_cycle();
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b1;
        do @(negedge AXIS_ACLK); while (!s_axi_rvalid);
        data = s_axi_rdata;
        check("s_axi_rresp", 64'(s_axi_rresp), 64'd0);
        next_cycle();
        s_axi_rready = 1'b0;
    endtask

    // --------------------------------------------------
    // stream stimulus and model
    // --------------------------------------------------

    // random packet with its expected sign vector queued after the last beat
    task automatic send_packet(input int unsigned count);
        int unsigned      len;
        int               sum [DIM];
        logic [3:0]       item;
        logic [3:0]       rot;
        logic [LANE_W-1:0] ins;
        hv_t              rv;
        hv_t              expv;
        logic             hs;
        len = rand_below(20) + 1;
        for (int b = 0; b < DIM; b++) begin
            sum[b] = 0;
        end
        for (int unsigned n = 0; n < len; n++) begin
            for (int c = 0; c < CORE_NUM; c++) begin
                rot  = 4'(rand_below(16));
                item = 4'(rand_below(count));
                ins  = {8'(rand_below(256)), rot, item};
                s_axis_tdata[c*LANE_W +: LANE_W] = ins;
                // rotate left by rot then +1 / -1 per bit
                rv = (item_tab[item] << rot) | (item_tab[item] >> (DIM - rot));
                for (int b = 0; b < DIM; b++) begin
                    sum[b] = rv[b] ? sum[b] + 1 : sum[b] - 1;
                end
            end
            // idle gap before the beat
            repeat (rand_below(3)) next_cycle();
            s_axis_tvalid = 1'b1;
            s_axis_tlast  = (n == len - 1);
            do begin
                @(negedge AXIS_ACLK);
                hs = s_axis_tvalid && s_axis_tready;
                next_cycle();
            end while (!hs);
            s_axis_tvalid = 1'b0;
            s_axis_tlast  = 1'b0;
        end
        // bit set only for a strictly positive total
        for (int b = 0; b < DIM; b++) begin
            expv[b] = (sum[b] > 0);
        end
        exp_q.push_back(expv);
        sent++;
    endtask

    task automatic wait_output();
        while (received != sent) begin
            next_cycle();
        end
    endtask

    // offered beats must be refused while run is low
    task automatic check_gated(input int n);
        s_axis_tdata  = rand_word();
        s_axis_tvalid = 1'b1;
        s_axis_tlast  = 1'b1;
        repeat (n) begin
            @(negedge AXIS_ACLK);
            check("s_axis_tready", 64'(s_axis_tready), 64'd0);
            check("m_axis_tvalid", 64'(m_axis_tvalid), 64'd0);
            next_cycle();
        end
        s_axis_tvalid = 1'b0;
        s_axis_tlast  = 1'b0;
    endtask

    // --------------------------------------------------
    // output monitor sampled mid-cycle
    // --------------------------------------------------

    always @(negedge AXIS_ACLK) begin
        if (S_AXI_ARESETN) begin
            // stalled beat holds
            if (prev_stall) begin
                check("m_axis_tvalid", 64'(m_axis_tvalid), 64'd1);
                check("m_axis_tdata", m_axis_tdata, prev_data);
            end
            if (m_axis_tvalid) begin
                check("s_axis_tready", 64'(s_axis_tready), 64'd0);
            end
            if (m_axis_tvalid && m_axis_tready) begin
                if (exp_q.size() == 0) begin
                    $display("output beat appeared with no packet pending");
                    stop_run();
                end else begin
                    check("m_axis_tdata", m_axis_tdata, exp_q.pop_front());
                    check("m_axis_tlast", 64'(m_axis_tlast), 64'd1);
                    received++;
                end
            end
            prev_stall = m_axis_tvalid && !m_axis_tready;
            prev_data  = m_axis_tdata;
        end
    end

    always @(posedge AXIS_ACLK) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_run();
        end
    end

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------

    initial begin
        logic [31:0] rd;
        logic [31:0] addr;
        int unsigned cnt;
        seed          = 32'h4fb0;
        S_AXI_ARESETN = 1'b0;
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        s_axis_tdata  = '0;
        s_axis_tvalid = 1'b0;
        s_axis_tlast  = 1'b0;
        m_axis_tready = 1'b0;
        build_items();
        repeat (3) @(posedge AXIS_ACLK);
        #1;
        S_AXI_ARESETN = 1'b1;

        // outputs idle out of reset
        check("m_axis_tvalid", 64'(m_axis_tvalid), 64'd0);
        check("s_axis_tready", 64'(s_axis_tready), 64'd0);
        check("s_axi_bvalid", 64'(s_axi_bvalid), 64'd0);
        check("s_axi_rvalid", 64'(s_axi_rvalid), 64'd0);
        check_gated(8);

        // register readback
        cnt = rand_below(16) + 1;
        axil_write(REG_COUNT_ADDR, cnt);
        axil_read(REG_COUNT_ADDR, rd);
        check("s_axi_rdata", 64'(rd), 64'(cnt));
        axil_write(REG_MODE_ADDR, 32'd2);
        axil_read(REG_MODE_ADDR, rd);
        check("s_axi_rdata", 64'(rd), 64'd2);
        axil_write(REG_MODE_ADDR, 32'd0);
        axil_read(REG_MODE_ADDR, rd);
        check("s_axi_rdata", 64'(rd), 64'd0);
        // unmapped space reads zero and leaves the registers alone
        repeat (3) begin
            addr = 32'd8 + 32'(4 * rand_below(60));
            axil_write(addr, rand_word());
            axil_read(addr, rd);
            check("s_axi_rdata", 64'(rd), 64'd0);
        end
        axil_read(REG_COUNT_ADDR, rd);
        check("s_axi_rdata", 64'(rd), 64'(cnt));

        // generate with a fresh count then encode
        for (int round = 0; round < 2; round++) begin
            cnt = rand_below(16) + 1;
            axil_write(REG_COUNT_ADDR, cnt);
            axil_write(REG_MODE_ADDR, 32'd3);
            do axil_read(REG_MODE_ADDR, rd); while (rd[0]);
            check("s_axi_rdata", 64'(rd), 64'd2);
            // back-to-back packets stall on the pending result
            for (int p = 0; p < PKT_PER_ROUND; p++) begin
                send_packet(cnt);
            end
            wait_output();
        end

        // run off again
        axil_write(REG_MODE_ADDR, 32'd0);
        check_gated(8);
        check("received", 64'(received), 64'(sent));
        check("pending", 64'(exp_q.size()), 64'd0);

        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== filelist.f ====
hdc_pkg.sv
axil_regs.sv
item_gen.sv
hdc_core.sv
bundle_merge.sv
hdc_top.sv
tb_hdc_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the testbench, exit status follows the simulation
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_hdc_top \
    -f filelist.f -o sim_hdc &&
./obj_dir/sim_hdc ||
{ echo "simulation did not pass"; exit 1; }
